/* design/image_pipe_pkg.sv */
// ==============================
// Image pipe package
// Sizes, config word indices, FSM states and stream payload structs
// ==============================
package image_pipe_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int WORD_WIDTH    = 8;
  localparam int UNITS         = 4;
  // Largest kernel height, always odd
  localparam int KERNEL_H_MAX  = 3;
  localparam int UNITS_EDGES   = UNITS + KERNEL_H_MAX - 1;
  localparam int BITS_KERNEL_H = $clog2(KERNEL_H_MAX);

  // Word positions inside the configuration beat
  // Each flag sits in the LSB of its word
  localparam int I_IS_NOT_MAX = 0;
  localparam int I_IS_MAX     = 1;
  localparam int I_IS_LRELU   = 2;
  localparam int I_KERNEL_H_1 = 3;

  // ==============================
  // Types
  // ==============================
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Word 0 is the least significant word of a row
  typedef word_t [UNITS_EDGES-1:0] in_row_t;
  typedef word_t [UNITS-1:0]       out_row_t;

  typedef struct packed {
    logic                     is_not_max;
    logic                     is_max;
    logic                     is_lrelu;
    logic [BITS_KERNEL_H-1:0] kernel_h_1;
  } cfg_t;

  typedef enum logic [1:0] {
    SET_S,
    ONES_S,
    PASS_S
  } pipe_state_e;

  typedef struct packed {
    in_row_t row;
    logic    last;
  } in_beat_t;

  typedef struct packed {
    in_row_t row_1;
    in_row_t row_2;
    cfg_t    cfg;
  } pair_beat_t;

  // Flags are ordered is_not_max, is_max, is_lrelu from MSB down
  typedef struct packed {
    out_row_t   row_1;
    out_row_t   row_2;
    logic [2:0] flags;
  } out_beat_t;

endpackage

/* design/pipe_ctrl.sv */
// ==============================
// Pipe control
// Per-image FSM, config registers, ones-beat counter and lane handshakes
// ==============================
`timescale 1ns/1ps

module pipe_ctrl #(
  parameter int BEATS_3X3 = 4,
  parameter int BEATS_1X1 = 2
) (
  input  logic                        aclk,
  input  logic                        rst_n,
  input  logic                        lane_1_valid,
  input  logic                        lane_1_last,
  input  logic                        lane_2_valid,
  input  image_pipe_pkg::in_row_t     lane_1_cfg_row,
  input  logic                        pipe_ready,
  output logic                        lane_1_ready,
  output logic                        lane_2_ready,
  output logic                        pipe_valid,
  output image_pipe_pkg::pipe_state_e state,
  output image_pipe_pkg::cfg_t        cfg
);

  localparam int CNT_W = $clog2(BEATS_3X3 + BEATS_1X1 + 1);

  image_pipe_pkg::pipe_state_e state_next;
  image_pipe_pkg::cfg_t        cfg_in;
  logic [CNT_W-1:0]            ones_count;
  logic [CNT_W-1:0]            ones_last;
  logic                        lane_1_fire;
  logic                        pipe_fire;

  // Config fields pulled straight out of the first lane-1 beat
  assign cfg_in.is_not_max = lane_1_cfg_row[image_pipe_pkg::I_IS_NOT_MAX][0];
  assign cfg_in.is_max     = lane_1_cfg_row[image_pipe_pkg::I_IS_MAX][0];
  assign cfg_in.is_lrelu   = lane_1_cfg_row[image_pipe_pkg::I_IS_LRELU][0];
  assign cfg_in.kernel_h_1 =
    lane_1_cfg_row[image_pipe_pkg::I_KERNEL_H_1][image_pipe_pkg::BITS_KERNEL_H-1:0];

  // A 1x1 kernel needs fewer RELU config beats than a 3x3 one
  assign ones_last = (cfg.kernel_h_1 == '0) ? CNT_W'(BEATS_1X1 - 1) : CNT_W'(BEATS_3X3 - 1);

  assign lane_1_fire = lane_1_valid && lane_1_ready;
  assign pipe_fire   = pipe_valid && pipe_ready;

  // ==============================
  // Handshake decode
  // ==============================
  always_comb begin
    pipe_valid   = 1'b0;
    lane_1_ready = 1'b0;
    lane_2_ready = 1'b0;
    unique case (state)
      image_pipe_pkg::SET_S: begin
        // Config beat is swallowed here, nothing goes downstream
        lane_1_ready = pipe_ready;
      end
      image_pipe_pkg::ONES_S: begin
        pipe_valid = 1'b1;
      end
      default: begin
        if (cfg.is_max) begin
          // Both lanes move together so their rows stay paired
          pipe_valid   = lane_1_valid && lane_2_valid;
          lane_1_ready = pipe_ready && lane_2_valid;
          lane_2_ready = pipe_ready && lane_1_valid;
        end else begin
          pipe_valid   = lane_1_valid;
          lane_1_ready = pipe_ready;
        end
      end
    endcase
  end

  always_comb begin
    state_next = state;
    unique case (state)
      image_pipe_pkg::SET_S:  if (lane_1_fire) state_next = image_pipe_pkg::ONES_S;
      image_pipe_pkg::ONES_S: if (pipe_fire && ones_count == ones_last) state_next = image_pipe_pkg::PASS_S;
      default:                if (lane_1_fire && lane_1_last) state_next = image_pipe_pkg::SET_S;
    endcase
  end

  // ==============================
  // State, counter and config
  // ==============================
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= image_pipe_pkg::SET_S;
      ones_count <= '0;
      cfg        <= '0;
    end else begin
      state <= state_next;
      if (state == image_pipe_pkg::SET_S && lane_1_fire) begin
        cfg <= cfg_in;
      end
      if (state != image_pipe_pkg::ONES_S) begin
        ones_count <= '0;
      end else if (pipe_fire) begin
        ones_count <= ones_count + 1'b1;
      end
    end
  end

endmodule

/* design/lane_merge.sv */
// ==============================
// Lane merge
// Builds the paired output rows from the two lanes or the ones pattern
// ==============================
`timescale 1ns/1ps

module lane_merge (
  input  image_pipe_pkg::in_row_t     lane_1_row,
  input  image_pipe_pkg::in_row_t     lane_2_row,
  input  image_pipe_pkg::pipe_state_e state,
  input  image_pipe_pkg::cfg_t        cfg,
  output image_pipe_pkg::pair_beat_t  pipe_beat
);

  // First unpadded word of the row
  localparam int U_ONE = image_pipe_pkg::KERNEL_H_MAX / 2;

  logic ones_beat;

  assign ones_beat = (state == image_pipe_pkg::ONES_S);

  // ==============================
  // Row select
  // ==============================
  always_comb begin
    for (int u = 0; u < image_pipe_pkg::UNITS_EDGES; u++) begin
      if (ones_beat) begin
        // Single one at the first data word, zeros elsewhere keep toggling low
        pipe_beat.row_1[u] = (u == U_ONE) ? image_pipe_pkg::word_t'(1) : '0;
        pipe_beat.row_2[u] = (u == U_ONE) ? image_pipe_pkg::word_t'(1) : '0;
      end else begin
        pipe_beat.row_1[u] = lane_1_row[u];
        pipe_beat.row_2[u] = cfg.is_max ? lane_2_row[u] : lane_1_row[u];
      end
    end
  end

  // Ones beats are never shifted, so their kernel field reads zero
  always_comb begin
    pipe_beat.cfg = cfg;
    if (ones_beat) begin
      pipe_beat.cfg.kernel_h_1 = '0;
    end
  end

endmodule

/* design/shift_buffer.sv */
// ==============================
// Shift buffer
// De-centers each padded row and emits kernel_h_1+1 shifted beats
// ==============================
`timescale 1ns/1ps

module shift_buffer (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  image_pipe_pkg::pair_beat_t in_beat,
  output logic                       in_ready,
  output logic                       out_valid,
  output image_pipe_pkg::out_beat_t  out_beat,
  input  logic                       out_ready
);

  localparam int H_MID = image_pipe_pkg::KERNEL_H_MAX / 2;

  logic [image_pipe_pkg::BITS_KERNEL_H-1:0] count;
  image_pipe_pkg::in_row_t                  buf_1;
  image_pipe_pkg::in_row_t                  buf_2;
  logic [2:0]                               flags;
  logic                                     load;
  logic                                     shift;

  // Rows arrive padded around the center, but shifting runs from word 0 up.
  // Moving the row down by H_MID - h2 lines the first tap up with word 0
  function automatic image_pipe_pkg::in_row_t decenter(
    input image_pipe_pkg::in_row_t                  row,
    input logic [image_pipe_pkg::BITS_KERNEL_H-1:0] kernel_h_1
  );
    image_pipe_pkg::in_row_t result;
    int                      src;
    result = '0;
    for (int u = 0; u < image_pipe_pkg::UNITS_EDGES; u++) begin
      src = u + H_MID - int'(kernel_h_1 / 2);
      if (src < image_pipe_pkg::UNITS_EDGES) begin
        result[u] = row[src];
      end
    end
    return result;
  endfunction

  // ==============================
  // Handshake and count
  // ==============================
  // A new row is taken only once the last shifted beat leaves
  assign in_ready = (count == '0) && (!out_valid || out_ready);
  assign load     = in_valid && in_ready;
  assign shift    = out_valid && out_ready && (count != '0);

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      count     <= '0;
      out_valid <= 1'b0;
    end else if (load) begin
      count     <= in_beat.cfg.kernel_h_1;
      out_valid <= 1'b1;
    end else if (shift) begin
      count <= count - 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // ==============================
  // Row registers
  // ==============================
  always_ff @(posedge aclk) begin
    if (load) begin
      buf_1 <= decenter(in_beat.row_1, in_beat.cfg.kernel_h_1);
      buf_2 <= decenter(in_beat.row_2, in_beat.cfg.kernel_h_1);
      flags <= {in_beat.cfg.is_not_max, in_beat.cfg.is_max, in_beat.cfg.is_lrelu};
    end else if (shift) begin
      // One word toward index 0, zero enters at the top
      buf_1 <= buf_1 >> image_pipe_pkg::WORD_WIDTH;
      buf_2 <= buf_2 >> image_pipe_pkg::WORD_WIDTH;
    end
  end

  assign out_beat.row_1 = buf_1[image_pipe_pkg::UNITS-1:0];
  assign out_beat.row_2 = buf_2[image_pipe_pkg::UNITS-1:0];
  assign out_beat.flags = flags;

endmodule

/* design/out_slice.sv */
// ==============================
// Output slice
// Two-entry skid register stage with registered valid and payload
// ==============================
`timescale 1ns/1ps

module out_slice (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  image_pipe_pkg::out_beat_t in_beat,
  output logic                      in_ready,
  output logic                      out_valid,
  output image_pipe_pkg::out_beat_t out_beat,
  input  logic                      out_ready
);

  image_pipe_pkg::out_beat_t skid_beat;
  logic                      skid_valid;
  logic                      take;
  logic                      advance;

  // Ready comes from a flop so the upstream path stays short
  assign in_ready = !skid_valid;
  assign take     = in_valid && in_ready;
  assign advance  = out_ready || !out_valid;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (advance) begin
      out_valid  <= skid_valid || take;
      skid_valid <= 1'b0;
    end else if (take) begin
      // Main register is stalled, so park the beat in the skid entry
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance && (skid_valid || take)) begin
      out_beat <= skid_valid ? skid_beat : in_beat;
    end else if (!advance && take) begin
      skid_beat <= in_beat;
    end
  end

endmodule

/* design/image_pipe.sv */
// ==============================
// Image pipe top
// Lane control and merge feeding the shift buffer and output slice
// ==============================
`timescale 1ns/1ps

module image_pipe #(
  parameter int BEATS_3X3 = 4,
  parameter int BEATS_1X1 = 2
) (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      lane_1_valid,
  input  image_pipe_pkg::in_beat_t  lane_1_in,
  output logic                      lane_1_ready,
  input  logic                      lane_2_valid,
  input  image_pipe_pkg::in_beat_t  lane_2_in,
  output logic                      lane_2_ready,
  output logic                      out_valid,
  output image_pipe_pkg::out_beat_t out_beat,
  input  logic                      out_ready
);

  image_pipe_pkg::pipe_state_e state;
  image_pipe_pkg::cfg_t        cfg;
  image_pipe_pkg::pair_beat_t  pipe_beat;
  logic                        pipe_valid;
  logic                        pipe_ready;
  image_pipe_pkg::out_beat_t   sb_beat;
  logic                        sb_valid;
  logic                        sb_ready;

  pipe_ctrl #(
    .BEATS_3X3 (BEATS_3X3),
    .BEATS_1X1 (BEATS_1X1)
  ) u_ctrl (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .lane_1_valid   (lane_1_valid),
    .lane_1_last    (lane_1_in.last),
    .lane_2_valid   (lane_2_valid),
    .lane_1_cfg_row (lane_1_in.row),
    .pipe_ready     (pipe_ready),
    .lane_1_ready   (lane_1_ready),
    .lane_2_ready   (lane_2_ready),
    .pipe_valid     (pipe_valid),
    .state          (state),
    .cfg            (cfg)
  );

  lane_merge u_merge (
    .lane_1_row (lane_1_in.row),
    .lane_2_row (lane_2_in.row),
    .state      (state),
    .cfg        (cfg),
    .pipe_beat  (pipe_beat)
  );

  shift_buffer u_shift (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (pipe_valid),
    .in_beat   (pipe_beat),
    .in_ready  (pipe_ready),
    .out_valid (sb_valid),
    .out_beat  (sb_beat),
    .out_ready (sb_ready)
  );

  out_slice u_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (sb_valid),
    .in_beat   (sb_beat),
    .in_ready  (sb_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

endmodule

/* include/image_pipe_model.svh */
// ==============================
// Image pipe reference model
// Expands one image into the expected sequence of output beats
// ==============================
`ifndef IMAGE_PIPE_MODEL_SVH
`define IMAGE_PIPE_MODEL_SVH

function automatic image_pipe_pkg::cfg_t model_cfg(input image_pipe_pkg::in_row_t row);
  image_pipe_pkg::cfg_t cfg;
  cfg.is_not_max = row[image_pipe_pkg::I_IS_NOT_MAX][0];
  cfg.is_max     = row[image_pipe_pkg::I_IS_MAX][0];
  cfg.is_lrelu   = row[image_pipe_pkg::I_IS_LRELU][0];
  cfg.kernel_h_1 = row[image_pipe_pkg::I_KERNEL_H_1][image_pipe_pkg::BITS_KERNEL_H-1:0];
  return cfg;
endfunction

// Expand one paired row into kernel_h_1+1 shifted output beats
function automatic void model_expand(
  input image_pipe_pkg::in_row_t      row_1,
  input image_pipe_pkg::in_row_t      row_2,
  input image_pipe_pkg::cfg_t         cfg,
  ref   image_pipe_pkg::out_beat_t    exp_q[$]
);
  image_pipe_pkg::in_row_t   d_1;
  image_pipe_pkg::in_row_t   d_2;
  image_pipe_pkg::out_beat_t beat;
  int                        src;
  d_1 = '0;
  d_2 = '0;
  for (int u = 0; u < image_pipe_pkg::UNITS_EDGES; u++) begin
    src = u + image_pipe_pkg::KERNEL_H_MAX / 2 - int'(cfg.kernel_h_1 / 2);
    if (src < image_pipe_pkg::UNITS_EDGES) begin
      d_1[u] = row_1[src];
      d_2[u] = row_2[src];
    end
  end
  beat.flags = {cfg.is_not_max, cfg.is_max, cfg.is_lrelu};
  for (int j = 0; j <= int'(cfg.kernel_h_1); j++) begin
    beat.row_1 = d_1[image_pipe_pkg::UNITS-1:0];
    beat.row_2 = d_2[image_pipe_pkg::UNITS-1:0];
    exp_q.push_back(beat);
    d_1 = d_1 >> image_pipe_pkg::WORD_WIDTH;
    d_2 = d_2 >> image_pipe_pkg::WORD_WIDTH;
  end
endfunction

// Config beat becomes the ones beats, then every data row is expanded
function automatic void model_image(
  input image_pipe_pkg::in_beat_t  cfg_beat,
  input image_pipe_pkg::in_beat_t  rows_1[$],
  input image_pipe_pkg::in_beat_t  rows_2[$],
  input int                        beats_3x3,
  input int                        beats_1x1,
  ref   image_pipe_pkg::out_beat_t exp_q[$]
);
  image_pipe_pkg::cfg_t    cfg;
  image_pipe_pkg::cfg_t    ones_cfg;
  image_pipe_pkg::in_row_t ones;
  image_pipe_pkg::in_row_t row_2;
  int                      n_ones;
  cfg                 = model_cfg(cfg_beat.row);
  ones_cfg            = cfg;
  ones_cfg.kernel_h_1 = '0;
  ones                = '0;
  ones[image_pipe_pkg::KERNEL_H_MAX / 2] = image_pipe_pkg::word_t'(1);
  n_ones = (cfg.kernel_h_1 == '0) ? beats_1x1 : beats_3x3;
  for (int i = 0; i < n_ones; i++) begin
    model_expand(ones, ones, ones_cfg, exp_q);
  end
  foreach (rows_1[i]) begin
    row_2 = cfg.is_max ? rows_2[i].row : rows_1[i].row;
    model_expand(rows_1[i].row, row_2, cfg, exp_q);
  end
endfunction

`endif

/* tests/tb_image_pipe.sv */
// ==============================
// Image pipe testbench
// Feeds both lanes and checks output beats against the reference model
// ==============================
`timescale 1ns/1ps

module tb_image_pipe;

  localparam int BEATS_3X3 = 4;
  localparam int BEATS_1X1 = 2;
  localparam int TIMEOUT   = 2000;

  logic                      aclk;
  logic                      rst_n;
  logic                      lane_1_valid;
  logic                      lane_1_ready;
  logic                      lane_2_valid;
  logic                      lane_2_ready;
  logic                      out_valid;
  logic                      out_ready;
  image_pipe_pkg::in_beat_t  lane_1_in;
  image_pipe_pkg::in_beat_t  lane_2_in;
  image_pipe_pkg::out_beat_t out_beat;

  image_pipe_pkg::in_beat_t  lane_1_q[$];
  image_pipe_pkg::in_beat_t  lane_2_q[$];
  image_pipe_pkg::out_beat_t got_q[$];
  image_pipe_pkg::out_beat_t exp_q[$];
  int                        seen_count;
  int                        lane_2_count;
  int                        error_count;
  int                        pass_count;
  int                        fail_count;
  int                        gap_pct;
  int                        ready_low_pct;

  `include "image_pipe_model.svh"

  image_pipe #(
    .BEATS_3X3 (BEATS_3X3),
    .BEATS_1X1 (BEATS_1X1)
  ) UUT (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .lane_1_valid (lane_1_valid),
    .lane_1_in    (lane_1_in),
    .lane_1_ready (lane_1_ready),
    .lane_2_valid (lane_2_valid),
    .lane_2_in    (lane_2_in),
    .lane_2_ready (lane_2_ready),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .out_ready    (out_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // ==============================
  // Driver, monitor and compare
  // ==============================
  // A lane slot frees up when its beat transfers on this edge or when it is idle
  always @(posedge aclk) begin
    if (rst_n) begin
      if (!lane_1_valid || lane_1_ready) begin
        if (lane_1_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
          lane_1_valid <= 1'b1;
          lane_1_in    <= lane_1_q.pop_front();
        end else begin
          lane_1_valid <= 1'b0;
        end
      end
      if (!lane_2_valid || lane_2_ready) begin
        if (lane_2_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
          lane_2_valid <= 1'b1;
          lane_2_in    <= lane_2_q.pop_front();
        end else begin
          lane_2_valid <= 1'b0;
        end
      end
      out_ready <= ($urandom_range(99) >= ready_low_pct);
    end
  end

  always @(posedge aclk) begin
    if (rst_n && out_valid && out_ready) begin
      got_q.push_back(out_beat);
    end
    if (rst_n && lane_2_valid && lane_2_ready) begin
      lane_2_count++;
    end
  end

  always @(negedge aclk) begin
    while (got_q.size() > 0) begin
      seen_count++;
      if (exp_q.size() == 0) begin
        $display("Output beat 0x%h arrived with no expected beat pending", got_q.pop_front());
        error_count++;
      end else begin
        check_beat(got_q.pop_front(), exp_q.pop_front());
      end
    end
  end

  task automatic check_beat(
    input image_pipe_pkg::out_beat_t got,
    input image_pipe_pkg::out_beat_t exp
  );
    if (got.row_1 !== exp.row_1) begin
      $display("Mismatch row_1: got 0x%h, expected 0x%h", got.row_1, exp.row_1);
      error_count++;
    end
    if (got.row_2 !== exp.row_2) begin
      $display("Mismatch row_2: got 0x%h, expected 0x%h", got.row_2, exp.row_2);
      error_count++;
    end
    if (got.flags !== exp.flags) begin
      $display("Mismatch flags: got 0x%h, expected 0x%h", got.flags, exp.flags);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // Waits until every queued lane-1 beat is taken and every expected beat seen
  task automatic drain_and_count(input int base, input int expected);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || lane_1_q.size() != 0 || lane_1_valid) begin
      @(posedge aclk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: output beats still missing after 2000 cycles");
      end
    end
    // Quiet period so an extra beat would still be counted
    for (int i = 0; i < 20; i++) begin
      @(posedge aclk);
    end
    check_count("beat_count", seen_count - base, expected);
  endtask

  task automatic make_rows(input int n, ref image_pipe_pkg::in_beat_t q[$]);
    image_pipe_pkg::in_beat_t beat;
    q.delete();
    for (int i = 0; i < n; i++) begin
      for (int u = 0; u < image_pipe_pkg::UNITS_EDGES; u++) begin
        beat.row[u] = image_pipe_pkg::word_t'($urandom);
      end
      beat.last = (i == n - 1);
      q.push_back(beat);
    end
  endtask

  // Queues config beat and rows, extends the model queue, returns the beat count
  function automatic int queue_image(
    input logic                                     is_max,
    input logic                                     is_lrelu,
    input logic [image_pipe_pkg::BITS_KERNEL_H-1:0] kernel_h_1,
    input image_pipe_pkg::in_beat_t                 rows_1[$],
    input image_pipe_pkg::in_beat_t                 rows_2[$],
    input logic                                     push_lane_2
  );
    image_pipe_pkg::in_beat_t cfg_beat;
    int                       n_ones;
    // Upper bits of each config word are junk, only the low bits count
    for (int u = 0; u < image_pipe_pkg::UNITS_EDGES; u++) begin
      cfg_beat.row[u] = image_pipe_pkg::word_t'($urandom);
    end
    cfg_beat.row[image_pipe_pkg::I_IS_NOT_MAX][0] = !is_max;
    cfg_beat.row[image_pipe_pkg::I_IS_MAX][0]     = is_max;
    cfg_beat.row[image_pipe_pkg::I_IS_LRELU][0]   = is_lrelu;
    cfg_beat.row[image_pipe_pkg::I_KERNEL_H_1][image_pipe_pkg::BITS_KERNEL_H-1:0] = kernel_h_1;
    cfg_beat.last = 1'b0;
    if (is_max) begin
      model_image(cfg_beat, rows_1, rows_2, BEATS_3X3, BEATS_1X1, exp_q);
    end else begin
      model_image(cfg_beat, rows_1, rows_1, BEATS_3X3, BEATS_1X1, exp_q);
    end
    lane_1_q.push_back(cfg_beat);
    foreach (rows_1[i]) lane_1_q.push_back(rows_1[i]);
    if (push_lane_2) begin
      foreach (rows_2[i]) lane_2_q.push_back(rows_2[i]);
    end
    // Ones beats carry a zero kernel field, so each gives a single output beat
    n_ones = (kernel_h_1 == '0) ? BEATS_1X1 : BEATS_3X3;
    return n_ones + rows_1.size() * (int'(kernel_h_1) + 1);
  endfunction

  task automatic report_test(input int num, input string name, input int start);
    if (error_count == start) begin
      pass_count++;
      $display("Test %0d %s: passed", num, name);
    end else begin
      fail_count++;
      $display("Test %0d %s: failed with %0d errors", num, name, error_count - start);
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    image_pipe_pkg::in_beat_t rows_1[$];
    image_pipe_pkg::in_beat_t rows_2[$];
    int                       expected;
    int                       base;
    int                       start;
    void'($urandom(32'h10f6_1d98));
    rst_n         = 1'b0;
    lane_1_valid  = 1'b0;
    lane_2_valid  = 1'b0;
    lane_1_in     = '0;
    lane_2_in     = '0;
    out_ready     = 1'b0;
    seen_count    = 0;
    lane_2_count  = 0;
    error_count   = 0;
    pass_count    = 0;
    fail_count    = 0;
    gap_pct       = 0;
    ready_low_pct = 0;
    repeat (10) @(posedge aclk);
    rst_n <= 1'b1;

    start = error_count;
    base  = seen_count;
    make_rows(1, rows_1);
    expected = queue_image(1'b0, 1'b0, 2'd2, rows_1, rows_1, 1'b0);
    drain_and_count(base, expected);
    report_test(1, "ones beats for a 3-high kernel", start);

    // Lane 2 holds the next test's rows and must stay untouched here
    start = error_count;
    base  = seen_count;
    make_rows(3, rows_2);
    foreach (rows_2[i]) lane_2_q.push_back(rows_2[i]);
    make_rows(3, rows_1);
    expected = queue_image(1'b0, 1'b1, 2'd0, rows_1, rows_1, 1'b0);
    drain_and_count(base, expected);
    check_count("lane_2_transfers", lane_2_count, 0);
    report_test(2, "non-max image, 1-high kernel", start);

    start = error_count;
    base  = seen_count;
    make_rows(3, rows_1);
    expected = queue_image(1'b1, 1'b0, 2'd2, rows_1, rows_2, 1'b0);
    drain_and_count(base, expected);
    check_count("lane_2_transfers", lane_2_count, 3);
    report_test(3, "max image, 3-high kernel", start);

    start = error_count;
    base  = seen_count;
    make_rows(2, rows_1);
    make_rows(2, rows_2);
    expected = queue_image(1'b1, 1'b1, 2'd0, rows_1, rows_2, 1'b1);
    drain_and_count(base, expected);
    report_test(4, "flags on every beat", start);

    start         = error_count;
    base          = seen_count;
    gap_pct       = 30;
    ready_low_pct = 30;
    make_rows(3, rows_1);
    make_rows(3, rows_2);
    expected = queue_image(1'b1, 1'b1, 2'd2, rows_1, rows_2, 1'b1);
    make_rows(4, rows_1);
    expected += queue_image(1'b0, 1'b0, 2'd0, rows_1, rows_1, 1'b0);
    make_rows(2, rows_1);
    make_rows(2, rows_2);
    expected += queue_image(1'b1, 1'b0, 2'd0, rows_1, rows_2, 1'b1);
    drain_and_count(base, expected);
    gap_pct       = 0;
    ready_low_pct = 0;
    report_test(5, "random stalls over three images", start);

    start = error_count;
    base  = seen_count;
    make_rows(2, rows_1);
    expected = queue_image(1'b0, 1'b1, 2'd2, rows_1, rows_1, 1'b0);
    drain_and_count(base, expected);
    base = seen_count;
    make_rows(2, rows_1);
    expected = queue_image(1'b0, 1'b0, 2'd0, rows_1, rows_1, 1'b0);
    drain_and_count(base, expected);
    report_test(6, "new config after last", start);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* image_pipe.f */
design/image_pipe_pkg.sv
design/pipe_ctrl.sv
design/lane_merge.sv
design/shift_buffer.sv
design/out_slice.sv
design/image_pipe.sv
+incdir+include
tests/tb_image_pipe.sv
